// File: project.f
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/dcache_fsm.sv
src/refill_counter.sv
src/way_store.sv
src/store_buffer.sv
src/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - src/cache_geom_pkg.sv
  - src/cache_ctrl_pkg.sv
  - src/dcache_fsm.sv
  - src/refill_counter.sv
  - src/way_store.sv
  - src/store_buffer.sv
  - src/dcache_top.sv
  - target: test
    files:
      - bench/tb_mem_model.sv
      - bench/tb_dcache.sv

// File: bench/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_data;
    logic        wr_rdy;
    logic [7:0]  wb_count;
    logic [31:0] wb_addr;
    line_t       wb_data;

    // stimulus table, one entry per row in each queue
    string       row_name    [$];
    cache_op_t   row_op      [$];
    logic [31:0] row_addr    [$];
    logic [3:0]  row_strb    [$];
    logic [31:0] row_wdata   [$];
    logic [31:0] row_rdata   [$];
    logic        row_refill  [$];
    logic        row_wb      [$];
    logic [31:0] row_wb_addr [$];

    logic [31:0] ref_addr [$];  // word addresses written by stores
    logic [31:0] ref_word [$];

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    always #2 clk = ~clk;

    dcache_top uut (
        .clk, .reset, .valid, .req, .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    tb_mem_model mem (
        .clk, .reset, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .wb_count, .wb_addr, .wb_data
    );

    // ######################################################################
    // reference memory contents

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] a;
        logic [31:0] w;
        a = {addr[31:2], 2'b00};
        w = a ^ 32'hA5A5_0000;
        for (int k = 0; k < ref_addr.size(); k++) begin
            if (ref_addr[k] == a) w = ref_word[k];  // newest entry wins
        end
        return w;
    endfunction

    function automatic line_t expected_line(input logic [31:0] addr);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = expected_word({addr[31:4], 2'(k), 2'b00});
        end
        return l;
    endfunction

    task automatic record_store(input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data);
        logic [31:0] w;
        w = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        ref_addr.push_back({addr[31:2], 2'b00});
        ref_word.push_back(w);
    endtask

    // ######################################################################
    // checks

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: %s expected %h, got %h", name, what, expected, actual);
        end
    endtask

    task automatic check_idle_outputs(input string when);
        checks++;
        assert (rd_req === 1'b0 && wr_req === 1'b0 && data_ok === 1'b0
                && addr_ok === 1'b1) else begin
            errors++;
            $display("%s: rd_req, wr_req or data_ok is not low, or addr_ok is not high",
                     when);
        end
    endtask

    task automatic add_row(input string name, input cache_op_t op, input logic [31:0] addr,
                           input logic [3:0] strb, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic refill,
                           input logic wb, input logic [31:0] wb_line);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_strb.push_back(strb);
        row_wdata.push_back(wdata);
        row_rdata.push_back(exp_rdata);
        row_refill.push_back(refill);
        row_wb.push_back(wb);
        row_wb_addr.push_back(wb_line);
    endtask

    // set 0x23 gets tags 1 to 5, the fifth evicts the dirty tag 1 line
    task automatic build_table();
        add_row("cold_load",      LOAD,  32'h0000_1234, 4'h0, 32'h0,
                32'hA5A5_1234, 1'b1, 1'b0, 32'h0);
        add_row("same_line_load", LOAD,  32'h0000_1238, 4'h0, 32'h0,
                32'hA5A5_1238, 1'b0, 1'b0, 32'h0);
        add_row("store_hit",      STORE, 32'h0000_1238, 4'b0011, 32'hDEAD_BEEF,
                32'h0, 1'b0, 1'b0, 32'h0);
        add_row("load_after_st",  LOAD,  32'h0000_1238, 4'h0, 32'h0,
                32'hA5A5_BEEF, 1'b0, 1'b0, 32'h0);
        add_row("fill_way1",      LOAD,  32'h0000_2230, 4'h0, 32'h0,
                32'hA5A5_2230, 1'b1, 1'b0, 32'h0);
        add_row("fill_way2",      LOAD,  32'h0000_3230, 4'h0, 32'h0,
                32'hA5A5_3230, 1'b1, 1'b0, 32'h0);
        add_row("fill_way3",      LOAD,  32'h0000_4230, 4'h0, 32'h0,
                32'hA5A5_4230, 1'b1, 1'b0, 32'h0);
        add_row("evict_dirty",    LOAD,  32'h0000_5230, 4'h0, 32'h0,
                32'hA5A5_5230, 1'b1, 1'b1, 32'h0000_1230);
        add_row("reload_stored",  LOAD,  32'h0000_1238, 4'h0, 32'h0,
                32'hA5A5_BEEF, 1'b1, 1'b0, 32'h0);
        add_row("store_miss",     STORE, 32'h0000_3344, 4'b1100, 32'h1234_5678,
                32'h0, 1'b1, 1'b0, 32'h0);
        add_row("load_merged",    LOAD,  32'h0000_3344, 4'h0, 32'h0,
                32'h1234_3344, 1'b0, 1'b0, 32'h0);
        add_row("load_neighbor",  LOAD,  32'h0000_3348, 4'h0, 32'h0,
                32'hA5A5_3348, 1'b0, 1'b0, 32'h0);
    endtask

    // ######################################################################
    // one table row from request to data_ok

    task automatic apply_row(input int i);
        cpu_req_t    r;
        logic        saw_read;
        logic [31:0] read_addr;
        logic [7:0]  wb_before;
        logic [31:0] got;
        logic        done;
        line_t       line_exp;
        r.op      = row_op[i];
        r.tag     = row_addr[i][31:12];
        r.index   = row_addr[i][11:4];
        r.offset  = row_addr[i][3:0];
        r.wstrb   = row_strb[i];
        r.wdata   = row_wdata[i];
        saw_read  = 1'b0;
        read_addr = '0;
        wb_before = wb_count;
        done      = 1'b0;
        if (row_op[i] == STORE) record_store(row_addr[i], row_strb[i], row_wdata[i]);
        valid <= 1'b1;
        req   <= r;
        @(posedge clk);
        while (!addr_ok) @(posedge clk);  // hazard or busy FSM holds it off
        valid <= 1'b0;
        while (!done) begin
            @(posedge clk);
            if (rd_req) begin
                saw_read  = 1'b1;
                read_addr = rd_addr;
            end
            done = data_ok;
        end
        got = rdata;
        if (row_op[i] == LOAD) compare_value(row_name[i], "rdata", row_rdata[i], got);
        checks++;
        if (row_refill[i]) begin
            assert (saw_read) else begin
                errors++;
                $display("%s: the miss never requested a line from memory", row_name[i]);
            end
            compare_value(row_name[i], "rd_addr", row_addr[i] & 32'hFFFF_FFF0, read_addr);
        end else begin
            assert (!saw_read) else begin
                errors++;
                $display("%s: a hit raised rd_req", row_name[i]);
            end
        end
        if (row_wb[i]) begin
            compare_value(row_name[i], "write-back count", 32'(wb_before) + 32'd1,
                          32'(wb_count));
            compare_value(row_name[i], "wr_addr", row_wb_addr[i], wb_addr);
            line_exp = expected_line(row_wb_addr[i]);
            for (int k = 0; k < 4; k++) begin
                compare_value(row_name[i], "wr_data word", line_exp[k*32 +: 32],
                              wb_data[k*32 +: 32]);
            end
        end else begin
            compare_value(row_name[i], "write-back count", 32'(wb_before), 32'(wb_count));
        end
    endtask

    initial begin
        reset = 1'b1;
        valid = 1'b0;
        req   = '0;
        build_table();
        cycle_limit = row_name.size() * 40;
        @(posedge clk);
        repeat (4) begin
            @(posedge clk);
            check_idle_outputs("during reset");
        end
        reset <= 1'b0;
        @(posedge clk);
        check_idle_outputs("first cycle after reset");
        for (int i = 0; i < row_name.size(); i++) begin
            apply_row(i);
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the cache did not finish the table within %0d cycles", cycle_limit);
        $display("%0d errors in %0d checks", errors, checks);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_req,
    input  logic [31:0]           rd_addr,
    output logic                  rd_rdy,
    output logic                  ret_valid,
    output logic                  ret_last,
    output logic [31:0]           ret_data,
    input  logic                  wr_req,
    input  logic [31:0]           wr_addr,
    input  cache_geom_pkg::line_t wr_data,
    output logic                  wr_rdy,
    output logic [7:0]            wb_count,
    output logic [31:0]           wb_addr,
    output cache_geom_pkg::line_t wb_data
);
    import cache_geom_pkg::*;

    logic [27:0] line_addr [16];  // lines written back so far
    line_t       line_data [16];
    int          num_lines;
    logic [31:0] rng;
    logic        rd_armed;
    logic [1:0]  rd_delay;
    logic        wr_armed;
    logic [1:0]  wr_delay;
    logic [27:0] ret_line;
    logic [2:0]  beats_left;
    logic [1:0]  beat;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // pattern word unless the line was written back
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] w;
        w = addr ^ 32'hA5A5_0000;
        for (int k = 0; k < num_lines; k++) begin
            if (line_addr[k] == addr[31:4]) w = line_data[k][addr[3:2]*32 +: 32];
        end
        return w;
    endfunction

    task automatic write_line(input logic [27:0] addr, input line_t data);
        int slot;
        slot = num_lines;
        for (int k = 0; k < num_lines; k++) begin
            if (line_addr[k] == addr) slot = k;
        end
        line_addr[slot] = addr;
        line_data[slot] = data;
        if (slot == num_lines) num_lines = num_lines + 1;
    endtask

    initial begin
        num_lines  = 0;
        rng        = 32'd71;
        rd_rdy     = 1'b0;
        wr_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        ret_data   = '0;
        rd_armed   = 1'b0;
        wr_armed   = 1'b0;
        beats_left = '0;
        wb_count   = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            rd_rdy     <= 1'b0;
            wr_rdy     <= 1'b0;
            ret_valid  <= 1'b0;
            ret_last   <= 1'b0;
            rd_armed   <= 1'b0;
            wr_armed   <= 1'b0;
            beats_left <= '0;
            wb_count   <= '0;
        end else begin
            // ##################################################################
            // read channel and four-beat return
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (beats_left != 0) begin
                ret_valid  <= 1'b1;
                ret_data   <= read_word({ret_line, beat, 2'b00});
                ret_last   <= beats_left == 3'd1;
                beat       <= beat + 2'd1;
                beats_left <= beats_left - 3'd1;
            end
            rd_rdy <= 1'b0;
            if (rd_req && rd_rdy) begin
                ret_line   <= rd_addr[31:4];
                beat       <= 2'd0;
                beats_left <= 3'd4;
            end else if (rd_armed) begin
                if (rd_delay == 0) begin
                    rd_rdy   <= 1'b1;
                    rd_armed <= 1'b0;
                end else begin
                    rd_delay <= rd_delay - 2'd1;
                end
            end else if (rd_req) begin
                rd_armed <= 1'b1;
                rd_delay <= rng[1:0];  // 0 to 3 extra cycles
                rng      <= xorshift32(rng);
            end
            // ##################################################################
            // write channel with log
            wr_rdy <= 1'b0;
            if (wr_req && wr_rdy) begin
                write_line(wr_addr[31:4], wr_data);
                wb_addr  <= wr_addr;
                wb_data  <= wr_data;
                wb_count <= wb_count + 8'd1;
            end else if (wr_armed) begin
                if (wr_delay == 0) begin
                    wr_rdy   <= 1'b1;
                    wr_armed <= 1'b0;
                end else begin
                    wr_delay <= wr_delay - 2'd1;
                end
            end else if (wr_req) begin
                wr_armed <= 1'b1;
                wr_delay <= rng[1:0];
                rng      <= xorshift32(rng);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                     clk,
    input  logic                     reset,
    // cpu
    input  logic                     valid,
    input  cache_ctrl_pkg::cpu_req_t req,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [31:0]              rdata,
    // memory
    output logic                     rd_req,
    output logic [31:0]              rd_addr,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  logic                     ret_last,
    input  logic [31:0]              ret_data,
    output logic                     wr_req,
    output logic [31:0]              wr_addr,
    output cache_geom_pkg::line_t    wr_data,
    input  logic                     wr_rdy
);
    import cache_geom_pkg::*;

    logic                  read_en;
    logic [INDEX_W-1:0]    read_index;
    logic [TAG_W-1:0]      cmp_tag;
    logic [WORD_SEL_W-1:0] cmp_word;
    fill_write_t           fill;
    logic                  fill_en;
    logic                  hit;
    way_t                  hit_way;
    logic [31:0]           load_word;
    way_t                  victim_way;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    line_t                 victim_line;
    store_entry_t          store_req;
    logic                  store_en;
    store_entry_t          store_wr;
    logic                  store_wr_en;
    logic                  store_pending;
    store_entry_t          pending_entry;
    logic                  beat_start;
    logic [1:0]            beat_idx;
    logic                  at_req_word;

    // no tag matches during refill, so hit picks between array and memory
    assign rdata   = hit ? load_word : ret_data;
    assign wr_data = victim_line;

    dcache_fsm u_fsm (
        .clk, .reset, .valid, .req, .addr_ok, .data_ok,
        .rd_req, .rd_addr, .rd_rdy, .wr_req, .wr_addr, .wr_rdy,
        .ret_valid, .ret_last, .ret_data,
        .read_en, .read_index, .cmp_tag, .cmp_word, .fill, .fill_en,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .store_req, .store_en, .store_pending, .pending_entry,
        .beat_start, .beat_idx, .at_req_word
    );

    refill_counter u_refill_counter (
        .clk, .reset,
        .start       (beat_start),
        .ret_valid,
        .req_word    (cmp_word),
        .beat_idx,
        .at_req_word
    );

    // pointer moves on a lookup hit and on the last refill beat,
    // so the victim way holds for the whole refill
    way_store u_way_store (
        .clk, .reset, .read_en, .read_index, .cmp_tag, .cmp_word,
        .lookup      ((data_ok && hit) || (fill_en && fill.last)),
        .fill, .fill_en, .store_wr, .store_wr_en,
        .hit, .hit_way, .load_word, .victim_way, .victim_dirty, .victim_tag, .victim_line
    );

    store_buffer u_store_buffer (
        .clk, .reset, .store_req, .store_en, .store_wr, .store_wr_en,
        .pending       (store_pending),
        .pending_entry
    );

endmodule

`default_nettype wire

// File: src/store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module store_buffer (
    input  logic                         clk,
    input  logic                         reset,
    input  cache_geom_pkg::store_entry_t store_req,
    input  logic                         store_en,
    output cache_geom_pkg::store_entry_t store_wr,
    output logic                         store_wr_en,
    output logic                         pending,
    output cache_geom_pkg::store_entry_t pending_entry
);
    import cache_geom_pkg::*;

    store_entry_t entry_q;
    logic         full_q;

    // a new hit store may land in the same cycle the old one drains
    always_ff @(posedge clk) begin
        if (reset) begin
            full_q <= 1'b0;
        end else begin
            full_q <= store_en;
        end
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            entry_q <= store_req;
        end
    end

    assign store_wr      = entry_q;
    assign store_wr_en   = full_q;
    assign pending       = full_q;  // read by the hazard check
    assign pending_entry = entry_q;

endmodule

`default_nettype wire

// File: src/way_store.sv
`timescale 1ns/100ps
`default_nettype none

module way_store (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  read_en,
    input  logic [cache_geom_pkg::INDEX_W-1:0]    read_index,
    input  logic [cache_geom_pkg::TAG_W-1:0]      cmp_tag,
    input  logic [cache_geom_pkg::WORD_SEL_W-1:0] cmp_word,
    input  logic                                  lookup,
    input  cache_geom_pkg::fill_write_t           fill,
    input  logic                                  fill_en,
    input  cache_geom_pkg::store_entry_t          store_wr,
    input  logic                                  store_wr_en,
    output logic                                  hit,
    output cache_geom_pkg::way_t                  hit_way,
    output logic [31:0]                           load_word,
    output cache_geom_pkg::way_t                  victim_way,
    output logic                                  victim_dirty,
    output logic [cache_geom_pkg::TAG_W-1:0]      victim_tag,
    output cache_geom_pkg::line_t                 victim_line
);
    import cache_geom_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]    tag_mem   [NUM_WAYS][SETS];
    line_t               data_mem  [NUM_WAYS][SETS];
    logic                dirty_mem [NUM_WAYS][SETS];
    logic [NUM_WAYS-1:0] valid_q   [SETS];
    way_t                repl_ptr  [SETS];

    logic [INDEX_W-1:0]  index_q;
    tag_entry_t          rd_tagv  [NUM_WAYS];
    logic                rd_dirty [NUM_WAYS];
    line_t               rd_line  [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_valid;

    // ######################################################################
    // synchronous read of all four ways
    // ######################################################################

    always_ff @(posedge clk) begin
        if (read_en) begin
            index_q <= read_index;
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tagv[w]  <= '{tag: tag_mem[w][read_index], valid: valid_q[read_index][w]};
                rd_dirty[w] <= dirty_mem[w][read_index];
                rd_line[w]  <= data_mem[w][read_index];
            end
        end
    end

    // refill beats and buffered stores
    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[fill.way][index_q][fill.word*32 +: 32] <= fill.data;
            if (fill.last) begin
                tag_mem[fill.way][index_q]   <= cmp_tag;
                dirty_mem[fill.way][index_q] <= fill.dirty;
            end
        end
        if (store_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (store_wr.wstrb[b]) begin
                    data_mem[store_wr.way][store_wr.index][store_wr.word*32 + b*8 +: 8]
                        <= store_wr.data[b*8 +: 8];
                end
            end
            dirty_mem[store_wr.way][store_wr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s]  <= '0;
                repl_ptr[s] <= '0;
            end
        end else begin
            if (fill_en && fill.last) begin
                valid_q[index_q][fill.way] <= 1'b1;
            end
            if (lookup) begin
                repl_ptr[index_q] <= hit ? hit_way + 2'd1 : victim_way + 2'd1;  // wraps mod 4
            end
        end
    end

    // ######################################################################
    // tag compare and victim choice
    // ######################################################################

    always_comb begin
        hit_way    = '0;
        victim_way = repl_ptr[index_q];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            way_valid[w] = rd_tagv[w].valid;
            way_hit[w]   = rd_tagv[w].valid && rd_tagv[w].tag == cmp_tag;
            if (way_hit[w]) hit_way = way_t'(w);
            if (!rd_tagv[w].valid) victim_way = way_t'(w);  // lowest invalid way wins
        end
    end

    assign hit          = |way_hit;
    assign load_word    = rd_line[hit_way][cmp_word*32 +: 32];
    assign victim_dirty = way_valid[victim_way] && rd_dirty[victim_way];
    assign victim_tag   = rd_tagv[victim_way].tag;
    assign victim_line  = rd_line[victim_way];

    // a refill never duplicates a tag within a set
    assert property (@(posedge clk) disable iff (reset) $onehot0(way_hit));

endmodule

`default_nettype wire

// File: src/refill_counter.sv
`timescale 1ns/100ps
`default_nettype none

module refill_counter (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       ret_valid,
    input  logic [1:0] req_word,
    output logic [1:0] beat_idx,
    output logic       at_req_word
);

    logic [2:0] count_q;  // bit 2 set once all four beats are in

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (start) begin
            count_q <= '0;
        end else if (ret_valid) begin
            count_q <= count_q + 3'd1;
        end
    end

    assign beat_idx    = count_q[1:0];
    assign at_req_word = !count_q[2] && beat_idx == req_word;

    // memory must stop after the fourth beat
    assert property (@(posedge clk) disable iff (reset) ret_valid |-> !count_q[2]);

endmodule

`default_nettype wire

// File: src/dcache_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_fsm (
    input  logic                                      clk,
    input  logic                                      reset,
    // cpu side
    input  logic                                      valid,
    input  cache_ctrl_pkg::cpu_req_t                  req,
    output logic                                      addr_ok,
    output logic                                      data_ok,
    // memory side
    output logic                                      rd_req,
    output logic [31:0]                               rd_addr,
    input  logic                                      rd_rdy,
    output logic                                      wr_req,
    output logic [31:0]                               wr_addr,
    input  logic                                      wr_rdy,
    input  logic                                      ret_valid,
    input  logic                                      ret_last,
    input  logic [31:0]                               ret_data,
    // array side
    output logic                                      read_en,
    output logic [cache_geom_pkg::INDEX_W-1:0]        read_index,
    output logic [cache_geom_pkg::TAG_W-1:0]          cmp_tag,
    output logic [cache_geom_pkg::WORD_SEL_W-1:0]     cmp_word,
    output cache_geom_pkg::fill_write_t               fill,
    output logic                                      fill_en,
    input  logic                                      hit,
    input  cache_geom_pkg::way_t                      hit_way,
    input  cache_geom_pkg::way_t                      victim_way,
    input  logic                                      victim_dirty,
    input  logic [cache_geom_pkg::TAG_W-1:0]          victim_tag,
    // store buffer side
    output cache_geom_pkg::store_entry_t              store_req,
    output logic                                      store_en,
    input  logic                                      store_pending,
    input  cache_geom_pkg::store_entry_t              pending_entry,
    // refill counter side
    output logic                                      beat_start,
    input  logic [1:0]                                beat_idx,
    input  logic                                      at_req_word
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    main_state_t state_q;
    main_state_t state_d;
    cpu_req_t    req_q;
    logic        accept;
    logic        hazard;
    logic        match_lookup;
    logic        match_buffer;
    logic [31:0] merged;

    // ######################################################################
    // request acceptance and load-after-store hazard
    // ######################################################################

    assign match_lookup = req.index == req_q.index && req.offset[3:2] == req_q.offset[3:2];
    assign match_buffer = req.index == pending_entry.index
                       && req.offset[3:2] == pending_entry.word;

    assign hazard = req.op == LOAD
                 && ((state_q == LOOKUP && req_q.op == STORE && match_lookup)
                  || (store_pending && match_buffer));

    assign addr_ok = (state_q == IDLE || (state_q == LOOKUP && hit)) && !hazard;
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // set re-read once the store buffer has drained
    assign read_en    = accept || (state_q == VICTIM && !store_pending);
    assign read_index = (state_q == VICTIM) ? req_q.index : req.index;
    assign cmp_tag    = req_q.tag;
    assign cmp_word   = req_q.offset[3:2];

    // ######################################################################
    // main state machine
    // ######################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) state_d = LOOKUP;
            end
            LOOKUP: begin
                if (!hit) begin
                    state_d = VICTIM;
                end else if (!accept) begin
                    state_d = IDLE;
                end
            end
            VICTIM: begin
                if (!store_pending) state_d = WRITEBACK;
            end
            WRITEBACK: begin
                if (!victim_dirty || wr_rdy) state_d = REFILL_REQ;  // clean victim skips
            end
            REFILL_REQ: begin
                if (rd_rdy) state_d = REFILL;
            end
            REFILL: begin
                if (ret_valid && ret_last) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    assign data_ok = (state_q == LOOKUP && hit)
                  || (state_q == REFILL && ret_valid && at_req_word);

    // hit stores go to the buffer at the end of lookup
    assign store_en  = state_q == LOOKUP && hit && req_q.op == STORE;
    assign store_req = '{way:   hit_way,
                         index: req_q.index,
                         word:  req_q.offset[3:2],
                         wstrb: req_q.wstrb,
                         data:  req_q.wdata};

    // ######################################################################
    // memory requests and refill
    // ######################################################################

    assign wr_req  = state_q == WRITEBACK && victim_dirty;
    assign wr_addr = {victim_tag, req_q.index, 4'b0000};
    assign rd_req  = state_q == REFILL_REQ;
    assign rd_addr = {req_q.tag, req_q.index, 4'b0000};

    assign beat_start = state_q == REFILL_REQ && rd_rdy;

    always_comb begin
        merged = ret_data;
        for (int b = 0; b < 4; b++) begin
            if (req_q.wstrb[b]) merged[8*b +: 8] = req_q.wdata[8*b +: 8];
        end
    end

    assign fill_en = state_q == REFILL && ret_valid;
    assign fill    = '{way:   victim_way,
                       word:  beat_idx,
                       data:  (req_q.op == STORE && at_req_word) ? merged : ret_data,
                       last:  ret_last,
                       dirty: req_q.op == STORE};

    // a waiting write-back keeps its line address
    assert property (@(posedge clk) disable iff (reset)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr));

endmodule

`default_nettype wire

// File: src/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } cache_op_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        VICTIM,
        WRITEBACK,
        REFILL_REQ,
        REFILL
    } main_state_t;

    // cpu request, 69 bits
    typedef struct packed {
        cache_op_t                          op;
        logic [cache_geom_pkg::INDEX_W-1:0] index;
        logic [cache_geom_pkg::TAG_W-1:0]   tag;
        logic [3:0]                         offset;
        logic [3:0]                         wstrb;
        logic [31:0]                        wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

// File: src/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // address split: tag | index | word | byte
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int WORD_SEL_W     = 2;
    localparam int NUM_WAYS       = 4;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [1:0] way_t;

    typedef logic [WORDS_PER_LINE*32-1:0] line_t;  // word 0 in the low bits

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

    // one buffered store hit, 48 bits
    typedef struct packed {
        way_t                  way;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word;
        logic [3:0]            wstrb;
        logic [31:0]           data;
    } store_entry_t;

    typedef struct packed {
        way_t                  way;
        logic [WORD_SEL_W-1:0] word;
        logic [31:0]           data;
        logic                  last;   // tag and valid go in with this beat
        logic                  dirty;
    } fill_write_t;

endpackage

`default_nettype wire
